// ==== verilog.f ====
hdl/ros2_buf_pkg.sv
hdl/handoff_if.sv
hdl/byte_queue.sv
hdl/pub_data_arbiter.sv
hdl/buf_handoff.sv
hdl/ros2_buf_ctrl.sv
sim/buf_checker.sv
sim/tb_ros2_buf_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir

verilator --binary --timing -f verilog.f --top-module tb_ros2_buf_ctrl -o tb_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' "$LOG"; then
  echo "result: pass"
  exit 0
fi

echo "result: fail"
exit 1

// ==== sim/ros2_buf_tests.txt ====
# test en pub hand queue txd rxd grants flags, grants and flags as seen after the next edge
# en: ether sub. pub: ip_req ip_rel user_req user_rel.
# hand: sub_req sub_rel rxbuf_ip_rel rxbuf_user_rel txbuf_ip_rel txbuf_user_rel
# queue: tx_wr tx_rd rx_wr rx_last rx_rd. txd/rxd: hex byte, 1xx = random byte
# grants: pub sub rxbuf txbuf as ip,user pairs. flags: tx_full tx_empty rx_full rx_empty
1 00 0000 000000 00000 000 000 00000000 0101
1 01 0000 000000 00000 000 000 00100000 0101
1 10 0000 000000 00000 000 000 00001001 0101
1 11 0000 000000 00000 000 000 00101001 0101
2 11 1010 000000 00000 000 000 10101001 0101
2 11 0001 000000 00000 000 000 10101001 0101
2 11 0100 000000 00000 000 000 00101001 0101
2 11 0010 000000 00000 000 000 01101001 0101
2 11 1000 000000 00000 000 000 01101001 0101
2 11 0001 000000 00000 000 000 00101001 0101
3 11 0000 000001 00000 000 000 00101010 0101
3 11 0000 001010 00000 000 000 00100101 0101
3 11 0000 000101 00000 000 000 00101010 0101
3 11 0000 000010 00000 000 000 00101001 0101
3 11 0000 100000 00000 000 000 00011001 0101
3 10 0000 000000 00000 000 000 00001001 0101
3 10 0000 000000 00000 000 000 00001001 0101
3 11 0000 000000 00000 000 000 00011001 0101
3 11 0000 010000 00000 000 000 00101001 0101
4 11 0000 000000 10000 100 000 00101001 0001
4 11 0000 000000 10000 100 000 00101001 0001
4 11 0000 000000 10000 100 000 00101001 0001
4 11 0000 000000 10000 100 000 00101001 1001
4 11 0000 000000 10000 0ee 000 00101001 1001
4 11 0000 000000 01000 000 000 00101001 0001
4 11 0000 000000 01000 000 000 00101001 0001
4 11 0000 000000 01000 000 000 00101001 0001
4 11 0000 000000 01000 000 000 00101001 0101
4 11 0000 000000 01000 000 000 00101001 0101
5 11 0000 000000 10000 100 000 00101001 0001
5 11 0000 000000 11000 100 000 00101001 0001
5 11 0000 000000 01000 000 000 00101001 0101
5 11 0000 000000 00101 000 100 00101001 0100
5 11 0000 000000 00100 000 100 00101001 0100
5 11 0000 000000 00110 000 0a5 00101001 0100
5 11 0000 000000 00101 000 100 00101001 0100
5 11 0000 000000 00111 000 100 00101001 0100
5 11 0000 000000 00100 000 05a 00101001 0110
5 11 0000 000000 00101 000 100 00101001 0100
5 11 0000 000000 00001 000 000 00101001 0100
5 11 0000 000000 00001 000 000 00101001 0100
5 11 0000 000000 00001 000 000 00101001 0101

// ==== sim/tb_ros2_buf_ctrl.sv ====
// -------------------------------------------------------------------------
// testbench for the buffer controller, stepped from a table of vectors.
// -------------------------------------------------------------------------

`timescale 1ns/1ns

module tb_ros2_buf_ctrl;

  localparam int    TX_DEPTH  = 4;
  localparam int    RX_DEPTH  = 4;
  localparam string TEST_FILE = "sim/ros2_buf_tests.txt";

  typedef struct packed {
    logic [1:0] en;
    logic [3:0] pub;
    logic [5:0] hand;
    logic [4:0] queue;
    logic [8:0] tx_data;     // bit 8 asks for a random byte.
    logic [8:0] rx_data;
    logic [7:0] grants;
    logic [3:0] flags;
  } step_t;

  step_t steps [$];
  int    step_test [$];
  int    num_lines   = 0;
  int    cycle_cnt   = 0;
  int    cycle_limit = 0;
  int    seed;

  logic clk;
  logic rst_n;
  logic ether_en;
  logic sub_en;
  logic pub_ip_req;
  logic pub_ip_rel;
  logic pub_user_req;
  logic pub_user_rel;
  logic sub_user_req;
  logic sub_user_rel;
  logic rxbuf_ip_rel;
  logic rxbuf_user_rel;
  logic txbuf_ip_rel;
  logic txbuf_user_rel;
  logic tx_wr;
  logic tx_rd;
  logic rx_wr;
  logic rx_last;
  logic rx_rd;
  logic [7:0] tx_din;
  logic [7:0] rx_din;
  logic [7:0] tx_dout;
  logic [7:0] rx_dout;
  logic [7:0] grants;        // pub, sub, rxbuf, txbuf as ip/user pairs.
  logic tx_full;
  logic tx_empty;
  logic rx_full;
  logic rx_empty;
  logic rx_last_out;

  logic       step_valid;
  logic       run_done;
  int         cur_test;
  logic [7:0] exp_grants;
  logic [3:0] exp_flags;
  int         errors;
  int         checks;
  int         tests;
  int         bad_tests;
  logic       closed;

  ros2_buf_ctrl #(.TX_DEPTH(TX_DEPTH), .RX_DEPTH(RX_DEPTH)) ros2_buf_ctrl_i (
    .clk(clk), .rst_n(rst_n), .i_ether_en(ether_en), .i_sub_en(sub_en),
    .i_pub_ip_req(pub_ip_req), .i_pub_ip_rel(pub_ip_rel),
    .i_pub_user_req(pub_user_req), .i_pub_user_rel(pub_user_rel),
    .o_pub_ip_grant(grants[7]), .o_pub_user_grant(grants[6]),
    .i_sub_user_req(sub_user_req), .i_sub_user_rel(sub_user_rel),
    .o_sub_ip_grant(grants[5]), .o_sub_user_grant(grants[4]),
    .i_rxbuf_ip_rel(rxbuf_ip_rel), .i_rxbuf_user_rel(rxbuf_user_rel),
    .o_rxbuf_ip_grant(grants[3]), .o_rxbuf_user_grant(grants[2]),
    .i_txbuf_ip_rel(txbuf_ip_rel), .i_txbuf_user_rel(txbuf_user_rel),
    .o_txbuf_ip_grant(grants[1]), .o_txbuf_user_grant(grants[0]),
    .i_tx_wr(tx_wr), .i_tx_din(tx_din), .i_tx_rd(tx_rd),
    .o_tx_dout(tx_dout), .o_tx_full(tx_full), .o_tx_empty(tx_empty),
    .i_rx_wr(rx_wr), .i_rx_din(rx_din), .i_rx_last(rx_last), .i_rx_rd(rx_rd),
    .o_rx_dout(rx_dout), .o_rx_last(rx_last_out), .o_rx_full(rx_full),
    .o_rx_empty(rx_empty)
  );

  buf_checker #(.TX_DEPTH(TX_DEPTH), .RX_DEPTH(RX_DEPTH)) checker_i (
    .clk(clk), .i_valid(step_valid), .i_done(run_done), .i_test(cur_test),
    .i_exp_grants(exp_grants), .i_exp_flags(exp_flags),
    .i_tx_wr(tx_wr), .i_tx_din(tx_din), .i_tx_rd(tx_rd),
    .i_rx_wr(rx_wr), .i_rx_din(rx_din), .i_rx_last(rx_last), .i_rx_rd(rx_rd),
    .i_grants(grants), .i_tx_dout(tx_dout), .i_tx_full(tx_full), .i_tx_empty(tx_empty),
    .i_rx_dout(rx_dout), .i_rx_last_out(rx_last_out), .i_rx_full(rx_full),
    .i_rx_empty(rx_empty), .o_errors(errors), .o_checks(checks), .o_tests(tests),
    .o_bad_tests(bad_tests), .o_closed(closed)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout: the run did not end within %0d cycles", cycle_limit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  task automatic load_steps();
    int         fd;
    int         n;
    int         t;
    string      line;
    logic [1:0] en;
    logic [3:0] pub;
    logic [5:0] hand;
    logic [4:0] q;
    logic [8:0] txd;
    logic [8:0] rxd;
    logic [7:0] gr;
    logic [3:0] fl;
    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) begin
      $display("cannot open stimulus file %s", TEST_FILE);
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0) begin
          num_lines++;
          if (line.getc(0) != "#") begin
            n = $sscanf(line, "%d %b %b %b %b %h %h %b %b",
                        t, en, pub, hand, q, txd, rxd, gr, fl);
            if (n == 9) begin
              steps.push_back({en, pub, hand, q, txd, rxd, gr, fl});
              step_test.push_back(t);
            end
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic idle_inputs();
    {pub_ip_req, pub_ip_rel, pub_user_req, pub_user_rel} = 4'b0000;
    {sub_user_req, sub_user_rel, rxbuf_ip_rel, rxbuf_user_rel} = 4'b0000;
    {txbuf_ip_rel, txbuf_user_rel} = 2'b00;
    {tx_wr, tx_rd, rx_wr, rx_last, rx_rd} = 5'b00000;
  endtask

  task automatic apply_step(input step_t s, input int test);
    logic [31:0] rnd;
    {ether_en, sub_en} = s.en;
    {pub_ip_req, pub_ip_rel, pub_user_req, pub_user_rel} = s.pub;
    {sub_user_req, sub_user_rel, rxbuf_ip_rel, rxbuf_user_rel,
     txbuf_ip_rel, txbuf_user_rel} = s.hand;
    {tx_wr, tx_rd, rx_wr, rx_last, rx_rd} = s.queue;
    rnd = $random(seed);
    tx_din = s.tx_data[8] ? rnd[7:0] : s.tx_data[7:0];
    rnd = $random(seed);
    rx_din = s.rx_data[8] ? rnd[7:0] : s.rx_data[7:0];
    exp_grants = s.grants;
    exp_flags  = s.flags;
    cur_test   = test;
    step_valid = 1'b1;
  endtask

  initial begin
    seed       = 32'h6bed;
    rst_n      = 1'b0;
    ether_en   = 1'b0;
    sub_en     = 1'b0;
    tx_din     = 8'h00;
    rx_din     = 8'h00;
    step_valid = 1'b0;
    run_done   = 1'b0;
    cur_test   = 0;
    exp_grants = 8'h00;
    exp_flags  = 4'h0;
    idle_inputs();
    load_steps();
    cycle_limit = num_lines + 50;
    if (steps.size() == 0) begin
      $display("no test steps could be read from %s", TEST_FILE);
      $display("*** FAILED ***");
      $finish;
    end else begin
      repeat (10) @(posedge clk);
      #2 rst_n = 1'b1;
      foreach (steps[i]) begin
        @(posedge clk);
        #2 apply_step(steps[i], step_test[i]);
      end
      @(posedge clk);
      #2 idle_inputs();
      step_valid = 1'b0;
      @(posedge clk);
      #2 run_done = 1'b1;
      wait (closed);
      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests, bad_tests, checks, errors);
      if (errors == 0 && bad_tests == 0) begin
        $display("*** PASSED ***");
      end else begin
        $display("*** FAILED ***");
      end
      $finish;
    end
  end

endmodule

// ==== sim/buf_checker.sv ====
// -------------------------------------------------------------------------
// testbench checker: models both queues, compares grants, flags and data.
// -------------------------------------------------------------------------

`timescale 1ns/1ns

module buf_checker #(
  parameter int TX_DEPTH = 4,
  parameter int RX_DEPTH = 4
) (
  input  logic       clk,
  input  logic       i_valid,       // a step was driven in the last cycle.
  input  logic       i_done,
  input  int         i_test,
  input  logic [7:0] i_exp_grants,
  input  logic [3:0] i_exp_flags,
  input  logic       i_tx_wr,
  input  logic [7:0] i_tx_din,
  input  logic       i_tx_rd,
  input  logic       i_rx_wr,
  input  logic [7:0] i_rx_din,
  input  logic       i_rx_last,
  input  logic       i_rx_rd,
  input  logic [7:0] i_grants,
  input  logic [7:0] i_tx_dout,
  input  logic       i_tx_full,
  input  logic       i_tx_empty,
  input  logic [7:0] i_rx_dout,
  input  logic       i_rx_last_out,
  input  logic       i_rx_full,
  input  logic       i_rx_empty,
  output int         o_errors,
  output int         o_checks,
  output int         o_tests,
  output int         o_bad_tests,
  output logic       o_closed
);

  logic [7:0] tx_model [$];
  logic [8:0] rx_model [$];   // {data, last}.
  int         errors     = 0;
  int         checks     = 0;
  int         tests      = 0;
  int         bad_tests  = 0;
  int         cur_test   = -1;
  int         test_errs  = 0;
  int         test_steps = 0;
  logic       closed     = 1'b0;

  assign o_errors    = errors;
  assign o_checks    = checks;
  assign o_tests     = tests;
  assign o_bad_tests = bad_tests;
  assign o_closed    = closed;

  task automatic note_check(input bit ok, input string msg);
    checks++;
    if (!ok) begin
      errors++;
      test_errs++;
      $display("[ERROR] %0t ns: test %0d %s", $time, cur_test, msg);
    end
  endtask

  task automatic close_test();
    tests++;
    if (test_errs == 0) begin
      $display("test %0d: ok, %0d steps", cur_test, test_steps);
    end else begin
      bad_tests++;
      $display("test %0d: %0d errors in %0d steps", cur_test, test_errs, test_steps);
    end
  endtask

  always @(posedge clk) begin : step_check
    logic [7:0] exp_grants;
    logic [3:0] exp_flags;
    logic [3:0] flags;
    bit         tx_wr_ok;
    bit         tx_rd_ok;
    bit         rx_wr_ok;
    bit         rx_rd_ok;
    if (i_done && !closed) begin
      if (cur_test >= 0) begin
        close_test();
      end
      closed = 1'b1;
    end else if (i_valid) begin
      exp_grants = i_exp_grants;
      exp_flags  = i_exp_flags;
      if (i_test != cur_test) begin
        if (cur_test >= 0) begin
          close_test();
        end
        cur_test   = i_test;
        test_errs  = 0;
        test_steps = 0;
      end
      test_steps++;
      // same edge as the dut: pop the head, then append.
      tx_wr_ok = i_tx_wr && (tx_model.size() < TX_DEPTH);
      tx_rd_ok = i_tx_rd && (tx_model.size() > 0);
      rx_wr_ok = i_rx_wr && (rx_model.size() < RX_DEPTH);
      rx_rd_ok = i_rx_rd && (rx_model.size() > 0);
      if (tx_rd_ok) void'(tx_model.pop_front());
      if (tx_wr_ok) tx_model.push_back(i_tx_din);
      if (rx_rd_ok) void'(rx_model.pop_front());
      if (rx_wr_ok) rx_model.push_back({i_rx_din, i_rx_last});
      #1;  // outputs have settled.
      flags = {i_tx_full, i_tx_empty, i_rx_full, i_rx_empty};
      note_check(i_grants === exp_grants,
                 $sformatf("grants %b, expected %b", i_grants, exp_grants));
      note_check(flags === exp_flags,
                 $sformatf("queue flags %b, expected %b", flags, exp_flags));
      if (tx_model.size() > 0) begin
        note_check(i_tx_dout === tx_model[0],
                   $sformatf("tx head %h, expected %h", i_tx_dout, tx_model[0]));
      end
      if (rx_model.size() > 0) begin
        note_check({i_rx_dout, i_rx_last_out} === rx_model[0],
                   $sformatf("rx head %h/%b, expected %h/%b", i_rx_dout, i_rx_last_out,
                             rx_model[0][8:1], rx_model[0][0]));
      end
    end
  end

endmodule

// ==== hdl/ros2_buf_ctrl.sv ====
// -------------------------------------------------------------------------
// buffer ownership arbiters and byte queues of the ros 2 ethernet wrapper.
// -------------------------------------------------------------------------

`timescale 1ns/1ns

module ros2_buf_ctrl #(
  parameter int TX_DEPTH = ros2_buf_pkg::DEF_TX_DEPTH,
  parameter int RX_DEPTH = ros2_buf_pkg::DEF_RX_DEPTH
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                i_ether_en,
  input  logic                i_sub_en,
  // publisher app data.
  input  logic                i_pub_ip_req,
  input  logic                i_pub_ip_rel,
  input  logic                i_pub_user_req,
  input  logic                i_pub_user_rel,
  output logic                o_pub_ip_grant,
  output logic                o_pub_user_grant,
  // subscriber app data buffer.
  input  logic                i_sub_user_req,
  input  logic                i_sub_user_rel,
  output logic                o_sub_ip_grant,
  output logic                o_sub_user_grant,
  // udp receive buffer.
  input  logic                i_rxbuf_ip_rel,
  input  logic                i_rxbuf_user_rel,
  output logic                o_rxbuf_ip_grant,
  output logic                o_rxbuf_user_grant,
  // udp transmit buffer.
  input  logic                i_txbuf_ip_rel,
  input  logic                i_txbuf_user_rel,
  output logic                o_txbuf_ip_grant,
  output logic                o_txbuf_user_grant,
  // transmit queue.
  input  logic                i_tx_wr,
  input  ros2_buf_pkg::byte_t i_tx_din,
  input  logic                i_tx_rd,
  output ros2_buf_pkg::byte_t o_tx_dout,
  output logic                o_tx_full,
  output logic                o_tx_empty,
  // receive queue.
  input  logic                i_rx_wr,
  input  ros2_buf_pkg::byte_t i_rx_din,
  input  logic                i_rx_last,
  input  logic                i_rx_rd,
  output ros2_buf_pkg::byte_t o_rx_dout,
  output logic                o_rx_last,
  output logic                o_rx_full,
  output logic                o_rx_empty
);

  import ros2_buf_pkg::*;

  // -----------------------------------------------------------------------
  // ownership arbiters
  // -----------------------------------------------------------------------

  pub_data_arbiter pub_arbiter (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_enable     (i_ether_en),
    .i_ip_req     (i_pub_ip_req),
    .i_ip_rel     (i_pub_ip_rel),
    .i_user_req   (i_pub_user_req),
    .i_user_rel   (i_pub_user_rel),
    .o_ip_grant   (o_pub_ip_grant),
    .o_user_grant (o_pub_user_grant)
  );

  handoff_if sub_hif ();
  handoff_if rxbuf_hif ();
  handoff_if txbuf_hif ();

  assign sub_hif.to_user   = i_sub_user_req;
  assign sub_hif.to_ip     = i_sub_user_rel;
  assign rxbuf_hif.to_user = i_rxbuf_ip_rel;   // ip hands the received data over.
  assign rxbuf_hif.to_ip   = i_rxbuf_user_rel;
  assign txbuf_hif.to_user = i_txbuf_ip_rel;   // ip done sending.
  assign txbuf_hif.to_ip   = i_txbuf_user_rel;

  buf_handoff #(.INIT_OWNER(OWNER_IP)) sub_handoff (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_enable (i_sub_en),
    .hif      (sub_hif)
  );

  buf_handoff #(.INIT_OWNER(OWNER_IP)) rxbuf_handoff (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_enable (i_ether_en),
    .hif      (rxbuf_hif)
  );

  buf_handoff #(.INIT_OWNER(OWNER_USER)) txbuf_handoff (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_enable (i_ether_en),
    .hif      (txbuf_hif)
  );

  assign o_sub_ip_grant     = sub_hif.ip_grant;
  assign o_sub_user_grant   = sub_hif.user_grant;
  assign o_rxbuf_ip_grant   = rxbuf_hif.ip_grant;
  assign o_rxbuf_user_grant = rxbuf_hif.user_grant;
  assign o_txbuf_ip_grant   = txbuf_hif.ip_grant;
  assign o_txbuf_user_grant = txbuf_hif.user_grant;

  // -----------------------------------------------------------------------
  // byte queues
  // -----------------------------------------------------------------------

  rx_beat_t rx_din_beat;
  rx_beat_t rx_dout_beat;

  assign rx_din_beat = '{data: i_rx_din, last: i_rx_last};
  assign o_rx_dout   = rx_dout_beat.data;
  assign o_rx_last   = rx_dout_beat.last;

  byte_queue #(.DEPTH(TX_DEPTH), .beat_t(tx_beat_t)) tx_queue (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_wr    (i_tx_wr),
    .i_din   (i_tx_din),
    .i_rd    (i_tx_rd),
    .o_dout  (o_tx_dout),
    .o_full  (o_tx_full),
    .o_empty (o_tx_empty)
  );

  byte_queue #(.DEPTH(RX_DEPTH), .beat_t(rx_beat_t)) rx_queue (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_wr    (i_rx_wr),
    .i_din   (rx_din_beat),
    .i_rd    (i_rx_rd),
    .o_dout  (rx_dout_beat),
    .o_full  (o_rx_full),
    .o_empty (o_rx_empty)
  );

endmodule

// ==== hdl/buf_handoff.sv ====
// -------------------------------------------------------------------------
// two-owner buffer hand-off between the ip and the user.
// -------------------------------------------------------------------------

`timescale 1ns/1ns

module buf_handoff #(
  parameter ros2_buf_pkg::owner_t INIT_OWNER = ros2_buf_pkg::OWNER_IP
) (
  input  logic clk,
  input  logic rst_n,
  input  logic i_enable,
  handoff_if.ctrl hif
);

  import ros2_buf_pkg::*;

  owner_t owner_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      owner_q <= INIT_OWNER;
    end else begin
      case (owner_q)
        OWNER_IP: begin
          if (hif.to_user) begin
            owner_q <= OWNER_USER;
          end
        end
        OWNER_USER: begin
          if (hif.to_ip) begin
            owner_q <= OWNER_IP;
          end
        end
      endcase
    end
  end

  // grants drop while disabled and the owner is kept.
  assign hif.ip_grant   = i_enable & (owner_q == OWNER_IP);
  assign hif.user_grant = i_enable & (owner_q == OWNER_USER);

endmodule

// ==== hdl/pub_data_arbiter.sv ====
// -------------------------------------------------------------------------
// publisher app data arbiter; ip wins a tie, owner holds until release.
// -------------------------------------------------------------------------

`timescale 1ns/1ns

module pub_data_arbiter (
  input  logic clk,
  input  logic rst_n,
  input  logic i_enable,
  input  logic i_ip_req,
  input  logic i_ip_rel,
  input  logic i_user_req,
  input  logic i_user_rel,
  output logic o_ip_grant,
  output logic o_user_grant
);

  import ros2_buf_pkg::*;

  pub_grant_t state_q;
  pub_grant_t state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      PUB_NONE: begin
        if (i_ip_req) begin
          state_d = PUB_IP;       // ip first, also on a tie.
        end else if (i_user_req) begin
          state_d = PUB_USER;
        end
      end
      PUB_IP: begin
        if (i_ip_rel) begin
          state_d = PUB_NONE;
        end
      end
      PUB_USER: begin
        if (i_user_rel) begin
          state_d = PUB_NONE;
        end
      end
      default: state_d = PUB_NONE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= PUB_NONE;
    end else begin
      state_q <= state_d;
    end
  end

  assign o_ip_grant   = i_enable & (state_q == PUB_IP);
  assign o_user_grant = i_enable & (state_q == PUB_USER);

endmodule

// ==== hdl/byte_queue.sv ====
// -------------------------------------------------------------------------
// first-word-fall-through queue with registered full and empty flags.
// -------------------------------------------------------------------------

`timescale 1ns/1ns

module byte_queue #(
  parameter int  DEPTH  = ros2_buf_pkg::DEF_TX_DEPTH,
  parameter type beat_t = ros2_buf_pkg::byte_t
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  i_wr,
  input  beat_t i_din,
  input  logic  i_rd,
  output beat_t o_dout,
  output logic  o_full,
  output logic  o_empty
);

  localparam int AW = $clog2(DEPTH);
  localparam int CW = $clog2(DEPTH + 1);
  localparam logic [AW-1:0] LAST_IDX = AW'(DEPTH - 1);

  beat_t         mem [DEPTH];
  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic [CW-1:0] count_q;
  logic [CW-1:0] count_d;
  logic          wr_ok;
  logic          rd_ok;

  assign wr_ok = i_wr & ~o_full;   // drop writes while full.
  assign rd_ok = i_rd & ~o_empty;  // ignore reads while empty.

  always_comb begin
    case ({wr_ok, rd_ok})
      2'b10:   count_d = count_q + 1'b1;
      2'b01:   count_d = count_q - 1'b1;
      default: count_d = count_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      o_full   <= 1'b0;
      o_empty  <= 1'b1;
    end else begin
      if (wr_ok) begin
        wr_ptr_q <= (wr_ptr_q == LAST_IDX) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr_q <= (rd_ptr_q == LAST_IDX) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_d;
      o_full  <= (count_d == CW'(DEPTH));
      o_empty <= (count_d == '0);
    end
  end

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wr_ptr_q] <= i_din;
    end
  end

  assign o_dout = mem[rd_ptr_q];  // head beat.

endmodule

// ==== hdl/handoff_if.sv ====
// -------------------------------------------------------------------------
// request and grant lines of one two-owner buffer hand-off.
// -------------------------------------------------------------------------

`timescale 1ns/1ns

interface handoff_if;

  logic to_user;     // move ownership to the user.
  logic to_ip;       // move ownership back to the ip.
  logic ip_grant;
  logic user_grant;

  // requesting side.
  modport host (
    output to_user,
    output to_ip,
    input  ip_grant,
    input  user_grant
  );

  // arbiter side.
  modport ctrl (
    input  to_user,
    input  to_ip,
    output ip_grant,
    output user_grant
  );

endinterface

// ==== hdl/ros2_buf_pkg.sv ====
// -------------------------------------------------------------------------
// shared types for the buffer ownership arbiters and the byte queues.
// -------------------------------------------------------------------------

package ros2_buf_pkg;

  // ---------------------------------------------------------------------
  // ownership
  // ---------------------------------------------------------------------

  // owner of a shared buffer.
  typedef enum logic {
    OWNER_IP   = 1'b0,
    OWNER_USER = 1'b1
  } owner_t;

  // publisher app data arbiter state.
  typedef enum logic [1:0] {
    PUB_NONE = 2'b00,
    PUB_IP   = 2'b01,
    PUB_USER = 2'b10
  } pub_grant_t;

  // ---------------------------------------------------------------------
  // queue beats
  // ---------------------------------------------------------------------

  typedef logic [7:0] byte_t;

  typedef byte_t tx_beat_t;  // transmit side carries bare bytes.

  typedef struct packed {
    byte_t data;
    logic  last;             // end of packet.
  } rx_beat_t;

  localparam int DEF_TX_DEPTH = 16;
  localparam int DEF_RX_DEPTH = 32;

endpackage
